// File: src/fog_defines.svh
`ifndef FOG_DEFINES_SVH
`define FOG_DEFINES_SVH

// DAC word and output port width.
`define FOG_OUT_BITS 16

// Internal accumulator, ladder and step width.
`define FOG_ACC_BITS 32

// Clock cycles per modulation half, i.e. half the eigen-period.
`define FOG_HALF_PERIOD 4

`define FOG_DEMOD_PERIODS 2 // Full modulation periods per loop update.

`define FOG_MOD_AMP 4096 // Bias modulation amplitude in DAC counts.

// Loop gain as an arithmetic right shift of the demodulated sum.
`define FOG_LOOP_SHIFT 2

`endif

// File: src/fog_pkg.sv
`include "fog_defines.svh"

package fog_pkg;

	typedef enum logic {MOD_POS, MOD_NEG} mod_state_e;

	typedef enum logic [1:0] {DIR_HOLD, DIR_UP, DIR_DOWN} ramp_dir_e;

	// Bias level applied to the modulator in a given half period.
	function automatic logic signed [`FOG_OUT_BITS-1:0] mod_level(input mod_state_e s);
		logic signed [`FOG_OUT_BITS-1:0] amp;
		amp = `FOG_MOD_AMP;
		return (s == MOD_POS) ? amp : -amp;
	endfunction

	function automatic ramp_dir_e step_dir(input logic signed [`FOG_ACC_BITS-1:0] step);
		if (step > 0)
			return DIR_UP;
		if (step < 0)
			return DIR_DOWN;
		return DIR_HOLD; // A zero step leaves the ladder where it is.
	endfunction

endpackage

// File: src/ramp_ctrl_if.sv
`include "fog_defines.svh"

// Control bundle from the rate demodulator to the phase ramp generator.
// trig is a one-cycle strobe, the other signals are levels.
interface ramp_ctrl_if;

	logic signed [`FOG_ACC_BITS-1:0] step; // Ramp step, updated once per loop period.
	logic trig; // Last cycle of every modulation period.
	logic fb_on;
	logic signed [`FOG_OUT_BITS-1:0] mod; // Square-wave bias modulation.

	modport src (
		output step,
		output trig,
		output fb_on,
		output mod
	);

	modport dst (
		input step,
		input trig,
		input fb_on,
		input mod
	);

endinterface

// File: src/rate_demod.sv
`include "fog_defines.svh"

module rate_demod import fog_pkg::*; (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_fb_on,
	input logic signed [`FOG_OUT_BITS-1:0] i_adc,
	ramp_ctrl_if.src ctl
);

	localparam int HW = $clog2(`FOG_HALF_PERIOD + 1);
	localparam int PW = $clog2(`FOG_DEMOD_PERIODS + 1);
	localparam logic [HW-1:0] HALF_LAST = HW'(`FOG_HALF_PERIOD - 1);
	localparam logic [PW-1:0] PER_LAST = PW'(`FOG_DEMOD_PERIODS - 1);

	mod_state_e state_q;
	mod_state_e state_nxt;
	logic [HW-1:0] half_q;
	logic [HW-1:0] half_nxt;
	logic [PW-1:0] per_q;
	logic trig_q;
	logic signed [`FOG_OUT_BITS-1:0] mod_q;
	logic signed [`FOG_ACC_BITS-1:0] adc_ext;
	logic signed [`FOG_ACC_BITS-1:0] demod;
	logic signed [`FOG_ACC_BITS-1:0] sum_q;
	logic signed [`FOG_ACC_BITS-1:0] sum_nxt;
	logic signed [`FOG_ACC_BITS-1:0] step_q;
	logic loop_upd;

	// Half-period timing. The state flips after HALF_PERIOD cycles.
	always_comb begin
		half_nxt = half_q + 1'b1;
		state_nxt = state_q;
		if (half_q == HALF_LAST) begin
			half_nxt = '0;
			state_nxt = (state_q == MOD_POS) ? MOD_NEG : MOD_POS;
		end
	end

	// The first positive half runs from the first cycle after reset release.
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_q <= MOD_POS;
			half_q <= '0;
			mod_q <= mod_level(MOD_POS);
			trig_q <= 1'b0;
		end else begin
			state_q <= state_nxt;
			half_q <= half_nxt;
			mod_q <= mod_level(state_nxt);
			trig_q <= (state_nxt == MOD_NEG) && (half_nxt == HALF_LAST);
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			per_q <= '0;
		else if (trig_q)
			per_q <= (per_q == PER_LAST) ? '0 : per_q + 1'b1;
	end

	assign adc_ext = i_adc; // Sign extension to accumulator width.
	assign demod = (state_q == MOD_POS) ? adc_ext : -adc_ext;
	assign sum_nxt = sum_q + demod; // Includes the sample of the current cycle.
	assign loop_upd = trig_q && (per_q == PER_LAST);

	// First loop integrator. The step keeps growing until the demodulated error is zero.
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sum_q <= '0;
			step_q <= '0;
		end else if (!i_fb_on) begin
			sum_q <= '0;
			step_q <= '0;
		end else if (loop_upd) begin
			sum_q <= '0;
			step_q <= step_q + (sum_nxt >>> `FOG_LOOP_SHIFT);
		end else begin
			sum_q <= sum_nxt;
		end
	end

	assign ctl.step = step_q;
	assign ctl.trig = trig_q;
	assign ctl.fb_on = i_fb_on;
	assign ctl.mod = mod_q;

	// The ramp generator relies on one strobe per modulation period.
	a_trig_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		trig_q |=> !trig_q);

	a_step_off: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!i_fb_on |=> (step_q == '0));

endmodule

// File: src/phase_ramp_gen.sv
`include "fog_defines.svh"

module phase_ramp_gen import fog_pkg::*; (
	input logic i_clk,
	input logic i_rst_n,
	input logic [31:0] i_v2pi,
	ramp_ctrl_if.dst ctl,
	output logic signed [`FOG_OUT_BITS-1:0] o_ladder,
	output logic signed [`FOG_OUT_BITS-1:0] o_dac,
	output logic signed [`FOG_OUT_BITS-1:0] o_mod
);

	ramp_dir_e dir;
	logic signed [`FOG_ACC_BITS-1:0] ladder_q;
	logic signed [`FOG_ACC_BITS-1:0] ramp_q;
	logic signed [`FOG_ACC_BITS-1:0] mod_d;
	logic signed [`FOG_ACC_BITS-1:0] v2pi_p;
	logic signed [`FOG_ACC_BITS-1:0] v2pi_n;
	logic signed [`FOG_ACC_BITS-1:0] v2pi_s;
	logic signed [`FOG_ACC_BITS-1:0] v2pi_x2;
	logic signed [`FOG_ACC_BITS-1:0] ladder_sum;
	logic signed [`FOG_ACC_BITS-1:0] ramp_sum;
	logic signed [`FOG_ACC_BITS-1:0] step_mag;
	logic signed [`FOG_ACC_BITS-1:0] ladder_mag;

	assign dir = step_dir(ctl.step);
	assign v2pi_s = i_v2pi;
	assign v2pi_x2 = v2pi_s + v2pi_s; // Wrap distance of one full 4-pi span.
	assign ladder_sum = ladder_q + ctl.step;
	assign ramp_sum = ladder_q + mod_d;

	// Thresholds follow the scale factor one cycle late.
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			v2pi_p <= 32'sd5000;
			v2pi_n <= -32'sd5000;
			mod_d <= '0;
		end else begin
			v2pi_p <= v2pi_s;
			v2pi_n <= -v2pi_s;
			mod_d <= ctl.mod; // Aligns the modulation with the ladder register.
		end
	end

	// Staircase advances once per modulation period and resets at plus or minus 2 pi.
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ladder_q <= '0;
			ramp_q <= '0;
		end else if (!ctl.fb_on) begin
			ladder_q <= '0;
			ramp_q <= '0;
		end else if (ctl.trig) begin
			case (dir)
				DIR_UP: begin
					ladder_q <= (ladder_sum >= v2pi_p) ? ladder_sum - v2pi_x2 : ladder_sum;
					ramp_q <= (ramp_sum > v2pi_p) ? ramp_sum - v2pi_x2 : ramp_sum;
				end
				DIR_DOWN: begin
					ladder_q <= (ladder_sum <= v2pi_n) ? ladder_sum + v2pi_x2 : ladder_sum;
					ramp_q <= (ramp_sum < v2pi_n) ? ramp_sum + v2pi_x2 : ramp_sum;
				end
				default: begin
					ladder_q <= ladder_q;
					ramp_q <= ramp_q;
				end
			endcase
		end
	end

	assign o_ladder = ladder_q[`FOG_OUT_BITS-1:0];
	assign o_dac = ramp_q[`FOG_OUT_BITS-1:0];
	assign o_mod = mod_d[`FOG_OUT_BITS-1:0];

	assign step_mag = (ctl.step < 0) ? -ctl.step : ctl.step;
	assign ladder_mag = (ladder_q < 0) ? -ladder_q : ladder_q;

	// With a settled scale factor and a step smaller than 2 pi, one reset is
	// always enough to keep the ladder inside the 2 pi band.
	a_ladder_band: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(ctl.fb_on && ctl.trig && (step_mag < v2pi_s) && (v2pi_p == v2pi_s)
			&& (ladder_mag <= v2pi_s))
		|=> (ladder_mag <= $past(v2pi_s)));

endmodule

// File: src/fog_loop_top.sv
`include "fog_defines.svh"

// Closed-loop phase feedback core. The demodulator produces the ramp step
// and the period strobe, the ramp generator turns them into the DAC word.
module fog_loop_top (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_fb_on,
	input logic [31:0] i_v2pi,
	input logic signed [`FOG_OUT_BITS-1:0] i_adc,
	output logic signed [`FOG_OUT_BITS-1:0] o_dac,
	output logic signed [`FOG_OUT_BITS-1:0] o_ladder,
	output logic signed [`FOG_OUT_BITS-1:0] o_mod,
	output logic signed [`FOG_ACC_BITS-1:0] o_step,
	output logic o_trig
);

	ramp_ctrl_if ctl_if ();

	rate_demod u_demod (
		.i_clk (i_clk),
		.i_rst_n (i_rst_n),
		.i_fb_on (i_fb_on),
		.i_adc (i_adc),
		.ctl (ctl_if.src)
	);

	phase_ramp_gen u_ramp (
		.i_clk (i_clk),
		.i_rst_n (i_rst_n),
		.i_v2pi (i_v2pi),
		.ctl (ctl_if.dst),
		.o_ladder (o_ladder),
		.o_dac (o_dac),
		.o_mod (o_mod)
	);

	// Loop state made visible for rate readout and debug.
	assign o_step = ctl_if.step;
	assign o_trig = ctl_if.trig;

endmodule

// File: tb/tb_clk_gen.sv
module tb_clk_gen #(
	parameter int PERIOD_NS = 100,
	parameter int RESET_CYCLES = 5,
	parameter int RELEASE_DLY = 10
) (
	output logic o_clk,
	output logic o_rst_n
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD_NS / 2) o_clk = ~o_clk;
	end

	// Reset is released a little after a rising edge, like every other input.
	initial begin
		o_rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		#(RELEASE_DLY);
		o_rst_n = 1'b1;
	end

endmodule

// File: tb/tb_fog_loop.sv
`include "fog_defines.svh"

module tb_fog_loop import fog_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int OUT_W = `FOG_OUT_BITS;
	localparam int HALF = `FOG_HALF_PERIOD;
	localparam int PERIOD = 2 * `FOG_HALF_PERIOD;
	localparam int LOOP_LEN = PERIOD * `FOG_DEMOD_PERIODS; // Cycles per loop update.
	localparam int AMP = `FOG_MOD_AMP;
	localparam int CLK_NS = 100;
	localparam int DRIVE_DLY = 10;
	localparam int RESET_CYCLES = 5;
	localparam int N_FIXED = 7;
	localparam int N_RAND = 4;
	localparam int N_ROWS = N_FIXED + N_RAND + 2;

	typedef struct {
		bit fb;
		int v2pi;
		int k; // ADC imbalance. The sample is +k in positive halves and -k in negative ones.
		int periods;
		int dstep; // Expected step change per loop update.
	} row_t;

	logic clk;
	logic rst_n;
	logic fb_on;
	logic [31:0] v2pi;
	logic signed [OUT_W-1:0] adc;
	logic signed [OUT_W-1:0] dac;
	logic signed [OUT_W-1:0] ladder;
	logic signed [OUT_W-1:0] mod;
	logic signed [`FOG_ACC_BITS-1:0] step;
	logic trig;

	row_t rows [N_ROWS];

	// Loop model state that mirrors the DUT registers.
	int m_step;
	int m_sum;
	int m_ladder;
	int m_ramp;
	int m_modd;
	int m_thr;

	int n_checks;
	longint watchdog_ns;
	bit table_ready = 1'b0;

	tb_clk_gen #(
		.PERIOD_NS (CLK_NS),
		.RESET_CYCLES (RESET_CYCLES),
		.RELEASE_DLY (DRIVE_DLY)
	) clk_gen (
		.o_clk (clk),
		.o_rst_n (rst_n)
	);

	fog_loop_top dut (
		.i_clk (clk),
		.i_rst_n (rst_n),
		.i_fb_on (fb_on),
		.i_v2pi (v2pi),
		.i_adc (adc),
		.o_dac (dac),
		.o_ladder (ladder),
		.o_mod (mod),
		.o_step (step),
		.o_trig (trig)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic signed [OUT_W-1:0] to_out(input int v);
		return v[OUT_W-1:0]; // The DAC sees the low bits of the 32-bit registers.
	endfunction

	// Cycle n counts from the first cycle after reset release.
	function automatic mod_state_e phase_of(input int n);
		if ((n % PERIOD) < HALF)
			return MOD_POS;
		return MOD_NEG;
	endfunction

	function automatic bit is_trig(input int n);
		return (n % PERIOD) == PERIOD - 1;
	endfunction

	function automatic bit is_update(input int n);
		return (n % LOOP_LEN) == LOOP_LEN - 1;
	endfunction

	task automatic check_val(input string name, input logic signed [63:0] exp_v,
			input logic signed [63:0] act_v);
		if (exp_v !== act_v) begin
			$display("** Error at %0d ns: %s expected %0d, actual %0d",
				$time, name, exp_v, act_v);
			$display("Result: FAILED");
			$fatal(1, "Mismatch on %s", name);
		end else begin
			n_checks++;
		end
	endtask

	task automatic load_rows();
		logic [31:0] rng;
		int k;
		int i;
		rng = 32'd6;
		rows[0] = '{1'b1, 20000, 0, 4, 0};
		rows[1] = '{1'b1, 20000, 40, 32, 160};
		rows[2] = '{1'b0, 20000, 40, 2, 0};
		rows[3] = '{1'b1, 20000, -50, 32, -200}; // Downward ramp.
		rows[4] = '{1'b0, 3000, 0, 2, 0};
		rows[5] = '{1'b1, 3000, 20, 24, 80}; // Small 2-pi voltage that forces frequent resets.
		rows[6] = '{1'b0, 3000, 20, 2, 0};
		for (i = 0; i < N_RAND; i++) begin
			rng = xorshift32(rng);
			k = int'(rng[5:0]) - 32;
			rows[N_FIXED + i] = '{1'b1, 12000, k, 8, (LOOP_LEN * k) >>> `FOG_LOOP_SHIFT};
		end
		rows[N_ROWS - 2] = '{1'b0, 12000, 0, 2, 0};
		rows[N_ROWS - 1] = '{1'b1, 12000, 0, 4, 0};
	endtask

	task automatic check_outputs(input int n);
		check_val("o_trig", is_trig(n), trig);
		check_val("o_mod", to_out(m_modd), mod);
		check_val("o_step", m_step, step);
		check_val("o_ladder", to_out(m_ladder), ladder);
		check_val("o_dac", to_out(m_ramp), dac);
	endtask

	// Moves the model across one clock edge, using the inputs of cycle n.
	task automatic model_advance(input bit f, input int v, input int a, input int n);
		int d;
		int lsum;
		int rsum;
		ramp_dir_e dir;
		d = (phase_of(n) == MOD_POS) ? a : -a;
		if (m_step > 0)
			dir = DIR_UP;
		else if (m_step < 0)
			dir = DIR_DOWN;
		else
			dir = DIR_HOLD;
		lsum = m_ladder + m_step;
		rsum = m_ladder + m_modd;
		if (!f) begin
			m_sum = 0;
			m_step = 0;
			m_ladder = 0;
			m_ramp = 0;
		end else begin
			if (is_trig(n) && dir == DIR_UP) begin
				m_ladder = (lsum >= m_thr) ? lsum - 2 * v : lsum;
				m_ramp = (rsum > m_thr) ? rsum - 2 * v : rsum;
			end else if (is_trig(n) && dir == DIR_DOWN) begin
				m_ladder = (lsum <= -m_thr) ? lsum + 2 * v : lsum;
				m_ramp = (rsum < -m_thr) ? rsum + 2 * v : rsum;
			end
			if (is_update(n)) begin
				m_step = m_step + ((m_sum + d) >>> `FOG_LOOP_SHIFT);
				m_sum = 0;
			end else begin
				m_sum = m_sum + d;
			end
		end
		m_modd = (phase_of(n) == MOD_POS) ? AMP : -AMP;
		m_thr = v; // Threshold register follows the scale factor one cycle late.
	endtask

	initial begin : stimulus
		int r;
		int c;
		int n;
		int total;
		int lad_mag;
		int step_delta;
		bit step_pending;
		logic signed [`FOG_ACC_BITS-1:0] step_base;
		fb_on = 1'b0;
		v2pi = 32'd5000;
		adc = '0;
		m_step = 0;
		m_sum = 0;
		m_ladder = 0;
		m_ramp = 0;
		m_modd = 0;
		m_thr = 5000;
		n_checks = 0;
		step_pending = 1'b0;
		step_base = '0;
		step_delta = 0;
		load_rows();
		total = 0;
		for (r = 0; r < N_ROWS; r++)
			total += rows[r].periods * PERIOD;
		watchdog_ns = longint'(RESET_CYCLES + total + 50) * CLK_NS;
		table_ready = 1'b1;

		@(posedge rst_n);
		n = 0;
		for (r = 0; r < N_ROWS; r++) begin
			for (c = 0; c < rows[r].periods * PERIOD; c++) begin
				check_outputs(n);
				if (step_pending) begin
					check_val("o_step change", step_delta, step - step_base);
					step_pending = 1'b0;
				end
				if (rows[r].fb) begin
					lad_mag = (ladder < 0) ? -ladder : ladder;
					check_val("ladder_in_band", 1, lad_mag <= rows[r].v2pi);
				end
				if (is_update(n) && rows[r].fb) begin
					step_pending = 1'b1; // New step shows up one cycle later.
					step_base = step;
					step_delta = rows[r].dstep;
				end
				fb_on = rows[r].fb;
				v2pi = rows[r].v2pi;
				adc = to_out((phase_of(n) == MOD_POS) ? rows[r].k : -rows[r].k);
				model_advance(rows[r].fb, rows[r].v2pi, int'(adc), n);
				@(posedge clk);
				#(DRIVE_DLY);
				n++;
			end
		end

		$display("%0d cycles, %0d checks", n, n_checks);
		$display("Result: PASSED");
		$finish;
	end

	initial begin : watchdog
		wait (table_ready);
		#(watchdog_ns);
		$display("Watchdog timeout: the stimulus table did not finish within %0d ns",
			watchdog_ns);
		$display("Result: FAILED");
		$fatal(1, "Simulation timed out");
	end

endmodule

// File: build.f
+incdir+src
src/fog_pkg.sv
src/ramp_ctrl_if.sv
src/rate_demod.sv
src/phase_ramp_gen.sv
src/fog_loop_top.sv
tb/tb_clk_gen.sv
tb/tb_fog_loop.sv

// File: run_sim.sh
#!/bin/sh
# Builds the FOG loop testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f build.f --top-module tb_fog_loop -o sim_fog_loop

./obj_dir/sim_fog_loop > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
	echo "Simulation failed, see $LOG"
	exit 1
fi
if ! grep -q "Result: PASSED" "$LOG"; then
	echo "Simulation ended without a result, see $LOG"
	exit 1
fi
echo "Simulation passed"
